// ==== Bender.yml ====
package:
  name: cu_arbiter_control

sources:
  - files:
      - source/cu_arbiter_pkg.sv
      - source/cmd_stream_if.sv
      - source/cu_command_arbiter.sv
      - source/command_buffer.sv
      - source/bus_command_issue.sv
      - source/response_router.sv
      - source/done_count_reduce.sv
      - source/cu_arbiter_control.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cu_arbiter_control.sv

// ==== cu_arbiter_control.f ====
+incdir+tests
source/cu_arbiter_pkg.sv
source/cmd_stream_if.sv
source/cu_command_arbiter.sv
source/command_buffer.sv
source/bus_command_issue.sv
source/response_router.sv
source/done_count_reduce.sv
source/cu_arbiter_control.sv
tests/tb_cu_arbiter_control.sv

// ==== source/bus_command_issue.sv ====
//////////////////////////////////////////////////////////////////////
// Memory bus side of the read path. Requests the bus while commands
// wait, pops one on each grant and presents it for one cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module bus_command_issue (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	cmd_stream_if.sink                    in,
	input  wire logic                     mem_alfull,
	input  wire logic                     bus_grant,
	output logic                          bus_request,
	output logic                          read_command_valid,
	output cu_arbiter_pkg::read_command_t read_command
);

	// A grant pops the head
	assign in.ready = bus_grant;

	// Memory side back-pressure, for the buffer's view
	assign in.full = mem_alfull;

	// Request drops for a cycle after each grant, so it is
	// re-evaluated against the buffer state after the pop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			bus_request        <= 1'b0;
			read_command_valid <= 1'b0;
		end else begin
			bus_request        <= in.valid && !mem_alfull && !bus_grant;
			read_command_valid <= bus_grant;
		end
	end

	always_ff @(posedge clock) begin
		if (bus_grant)
			read_command <= in.payload;
	end

	// Bus master grants only an open request
	a_grant_needs_request : assert property (@(posedge clock) disable iff (!rstn)
		bus_grant |-> bus_request);

endmodule

`default_nettype wire

// ==== source/cmd_stream_if.sv ====
//////////////////////////////////////////////////////////////////////
// Valid/ready stream of stamped read commands between design blocks.
// full is an almost-full hint from the sink back to the source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface cmd_stream_if;

	logic                          valid;
	logic                          ready;
	logic                          full;
	cu_arbiter_pkg::read_command_t payload;

	// Producer side
	modport source (output valid, output payload, input ready, input full);

	// Consumer side
	modport sink (input valid, input payload, output ready, output full);

endinterface

`default_nettype wire

// ==== source/command_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Circular FIFO of stamped read commands between arbiter and issue.
// Raises full upstream at the almost-full level so the arbiter's
// register always has a free slot to land in
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module command_buffer (
	input  wire logic  clock,
	input  wire logic  rstn,
	cmd_stream_if.sink   in,
	cmd_stream_if.source out
);

	logic [$clog2(cu_arbiter_pkg::CMD_BUFFER_DEPTH)-1:0] wr_ptr;
	logic [$clog2(cu_arbiter_pkg::CMD_BUFFER_DEPTH)-1:0] rd_ptr;
	logic [$clog2(cu_arbiter_pkg::CMD_BUFFER_DEPTH):0]   count;
	logic                                                push;
	logic                                                pop;

	cu_arbiter_pkg::read_command_t mem [cu_arbiter_pkg::CMD_BUFFER_DEPTH];

	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	// Status back upstream
	assign in.ready = (count != cu_arbiter_pkg::CMD_BUFFER_DEPTH);
	assign in.full  = (count >= cu_arbiter_pkg::CMD_ALFULL_LEVEL);

	// Head of queue
	assign out.valid   = (count != '0);
	assign out.payload = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= in.payload;
	end

	// Almost-full margin keeps the arbiter from ever seeing a full FIFO
	a_no_push_full : assert property (@(posedge clock) disable iff (!rstn)
		in.valid |-> in.ready);

	// Issue stage only pops while a command is queued
	a_no_pop_empty : assert property (@(posedge clock) disable iff (!rstn)
		out.ready |-> out.valid);

endmodule

`default_nettype wire

// ==== source/cu_arbiter_control.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the CU read-command arbiter. Merges CU read commands
// onto the memory bus, routes responses back and sums done counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_arbiter_control (
	input  wire logic                            clock,
	input  wire logic                            rstn,

	// CU read requests
	input  wire logic [cu_arbiter_pkg::NUM_CU-1:0] cu_req_valid,
	input  cu_arbiter_pkg::cu_read_req_t         cu_req [cu_arbiter_pkg::NUM_CU],
	output logic      [cu_arbiter_pkg::NUM_CU-1:0] cu_req_ready,

	// Memory command bus
	input  wire logic                            mem_alfull,
	input  wire logic                            bus_grant,
	output logic                                 bus_request,
	output logic                                 read_command_valid,
	output cu_arbiter_pkg::read_command_t        read_command,

	// Read responses
	input  wire logic                            read_response_valid,
	input  cu_arbiter_pkg::read_response_t       read_response,
	output logic      [cu_arbiter_pkg::NUM_CU-1:0] cu_resp_valid,
	output logic      [cu_arbiter_pkg::DATA_W-1:0] cu_resp,

	// Done counts
	input  cu_arbiter_pkg::vertex_count_t        vertex_done_partial [cu_arbiter_pkg::NUM_CU],
	input  cu_arbiter_pkg::edge_count_t          edge_done_partial [cu_arbiter_pkg::NUM_CU],
	output cu_arbiter_pkg::vertex_count_t        vertex_done_total,
	output cu_arbiter_pkg::edge_count_t          edge_done_total
);

	cmd_stream_if arb_to_buf ();
	cmd_stream_if buf_to_issue ();

	//////////////////////////////////////////////////////////////////////
	// Command path
	//////////////////////////////////////////////////////////////////////

	cu_command_arbiter cu_command_arbiter_inst (
		.clock       (clock),
		.rstn        (rstn),
		.cu_req_valid(cu_req_valid),
		.cu_req      (cu_req),
		.cu_req_ready(cu_req_ready),
		.out         (arb_to_buf.source)
	);

	command_buffer command_buffer_inst (
		.clock(clock),
		.rstn (rstn),
		.in   (arb_to_buf.sink),
		.out  (buf_to_issue.source)
	);

	bus_command_issue bus_command_issue_inst (
		.clock             (clock),
		.rstn              (rstn),
		.in                (buf_to_issue.sink),
		.mem_alfull        (mem_alfull),
		.bus_grant         (bus_grant),
		.bus_request       (bus_request),
		.read_command_valid(read_command_valid),
		.read_command      (read_command)
	);

	//////////////////////////////////////////////////////////////////////
	// Responses and done counts
	//////////////////////////////////////////////////////////////////////

	response_router response_router_inst (
		.clock              (clock),
		.rstn               (rstn),
		.read_response_valid(read_response_valid),
		.read_response      (read_response),
		.cu_resp_valid      (cu_resp_valid),
		.cu_resp            (cu_resp)
	);

	done_count_reduce #(
		.count_t(cu_arbiter_pkg::vertex_count_t)
	) vertex_count_reduce_inst (
		.clock  (clock),
		.rstn   (rstn),
		.partial(vertex_done_partial),
		.total  (vertex_done_total)
	);

	done_count_reduce #(
		.count_t(cu_arbiter_pkg::edge_count_t)
	) edge_count_reduce_inst (
		.clock  (clock),
		.rstn   (rstn),
		.partial(edge_done_partial),
		.total  (edge_done_total)
	);

endmodule

`default_nettype wire

// ==== source/cu_arbiter_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared sizes and record types for the CU read-command arbiter.
// Modules refer to these by scoped names, e.g. cu_arbiter_pkg::NUM_CU
//////////////////////////////////////////////////////////////////////

`default_nettype none

package cu_arbiter_pkg;

	// Compute unit count and index width
	localparam int NUM_CU  = 4;
	localparam int CU_ID_W = $clog2(NUM_CU);

	// Memory bus field widths
	localparam int ADDR_W = 32;
	localparam int SIZE_W = 8;
	localparam int DATA_W = 64;

	// Command buffer sizing
	localparam int CMD_BUFFER_DEPTH = 16;
	localparam int CMD_ALFULL_LEVEL = 12;

	// Done counter widths
	localparam int VERTEX_COUNT_W = 32;
	localparam int EDGE_COUNT_W   = 32;

	// Request as a CU issues it, before stamping
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [SIZE_W-1:0] size;
	} cu_read_req_t;

	// Stamped command as queued and sent on the memory bus
	typedef struct packed {
		logic [CU_ID_W-1:0] cu_id;
		logic [ADDR_W-1:0]  addr;
		logic [SIZE_W-1:0]  size;
	} read_command_t;

	// Read response, cu_id copied from the command
	typedef struct packed {
		logic [CU_ID_W-1:0] cu_id;
		logic [DATA_W-1:0]  data;
	} read_response_t;

	typedef logic [VERTEX_COUNT_W-1:0] vertex_count_t;
	typedef logic [EDGE_COUNT_W-1:0]   edge_count_t;

endpackage

`default_nettype wire

// ==== source/cu_command_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Round-robin merge of per-CU read requests into one command stream.
// The winner is stamped with its CU index and held in an output
// register until the downstream takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_command_arbiter (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic [cu_arbiter_pkg::NUM_CU-1:0]   cu_req_valid,
	input  cu_arbiter_pkg::cu_read_req_t             cu_req [cu_arbiter_pkg::NUM_CU],
	output logic      [cu_arbiter_pkg::NUM_CU-1:0]   cu_req_ready,
	cmd_stream_if.source                             out
);

	logic [cu_arbiter_pkg::CU_ID_W-1:0] last_ptr;
	logic [cu_arbiter_pkg::CU_ID_W-1:0] grant_idx;
	logic                               grant_found;
	logic                               can_load;
	logic                               take;
	logic                               out_valid;
	cu_arbiter_pkg::read_command_t      out_payload;

	//////////////////////////////////////////////////////////////////////
	// Grant selection
	//////////////////////////////////////////////////////////////////////

	// First valid CU after the last one served
	always_comb begin : pick
		logic [cu_arbiter_pkg::CU_ID_W-1:0] cand;
		grant_idx   = last_ptr;
		grant_found = 1'b0;
		for (int k = 1; k <= cu_arbiter_pkg::NUM_CU; k++) begin
			cand = last_ptr + cu_arbiter_pkg::CU_ID_W'(k);
			if (!grant_found && cu_req_valid[cand]) begin
				grant_idx   = cand;
				grant_found = 1'b1;
			end
		end
	end

	// Room when register is empty or draining, and buffer not near full
	assign can_load = (!out_valid || out.ready) && !out.full;
	assign take     = grant_found && can_load;

	assign cu_req_ready = take ? (cu_arbiter_pkg::NUM_CU'(1) << grant_idx) : '0;

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid <= 1'b0;
			// CU 0 wins first
			last_ptr  <= cu_arbiter_pkg::CU_ID_W'(cu_arbiter_pkg::NUM_CU - 1);
		end else begin
			if (take) begin
				out_valid <= 1'b1;
				last_ptr  <= grant_idx;
			end else if (out.ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			out_payload.cu_id <= grant_idx;
			out_payload.addr  <= cu_req[grant_idx].addr;
			out_payload.size  <= cu_req[grant_idx].size;
		end
	end

	assign out.valid   = out_valid;
	assign out.payload = out_payload;

	// Ready only goes to a CU that is asking
	a_ready_to_valid : assert property (@(posedge clock) disable iff (!rstn)
		(cu_req_ready & ~cu_req_valid) == '0);

	// A stalled command holds until the buffer takes it
	a_hold_stalled : assert property (@(posedge clock) disable iff (!rstn)
		out.valid && !out.ready |=> out.valid && $stable(out.payload));

endmodule

`default_nettype wire

// ==== source/done_count_reduce.sv ====
//////////////////////////////////////////////////////////////////////
// Registered sum of the per-CU done counters. count_t selects the
// counter type, one instance per count kind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module done_count_reduce #(
	parameter type count_t = cu_arbiter_pkg::vertex_count_t
) (
	input  wire logic clock,
	input  wire logic rstn,
	input  count_t    partial [cu_arbiter_pkg::NUM_CU],
	output count_t    total
);

	count_t sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i < cu_arbiter_pkg::NUM_CU; i++)
			sum = sum + partial[i];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			total <= '0;
		else
			total <= sum;
	end

endmodule

`default_nettype wire

// ==== source/response_router.sv ====
//////////////////////////////////////////////////////////////////////
// Steers each read response to the CU named in its cu_id.
// One register stage, data shared by all CUs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module response_router (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic                                read_response_valid,
	input  cu_arbiter_pkg::read_response_t           read_response,
	output logic [cu_arbiter_pkg::NUM_CU-1:0]        cu_resp_valid,
	output logic [cu_arbiter_pkg::DATA_W-1:0]        cu_resp
);

	// One-hot decode of the target CU
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_resp_valid <= '0;
		end else if (read_response_valid) begin
			cu_resp_valid <= cu_arbiter_pkg::NUM_CU'(1) << read_response.cu_id;
		end else begin
			cu_resp_valid <= '0;
		end
	end

	always_ff @(posedge clock) begin
		cu_resp <= read_response.data;
	end

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
//////////////////////////////////////////////////////////////////////
// Compare tasks for the CU arbiter testbench, one per result kind.
// Included inside the testbench module, the first mismatch ends the run
//////////////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Reason line, then the verdict, then stop
task automatic fail_run(input string reason);
	$display("%s", reason);
	$display("=== FAIL ===");
	$fatal(1, "stopped at first error");
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
	if (actual !== expected)
		fail_run($sformatf("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected));
endtask

// Per-CU valid and ready vectors
task automatic check_flags(input string name,
	input logic [cu_arbiter_pkg::NUM_CU-1:0] actual,
	input logic [cu_arbiter_pkg::NUM_CU-1:0] expected);
	if (actual !== expected)
		fail_run($sformatf("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected));
endtask

task automatic check_command(input string name,
	input cu_arbiter_pkg::read_command_t actual,
	input cu_arbiter_pkg::read_command_t expected);
	if (actual !== expected)
		fail_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected));
endtask

task automatic check_response(input string name,
	input cu_arbiter_pkg::read_response_t actual,
	input cu_arbiter_pkg::read_response_t expected);
	if (actual !== expected)
		fail_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected));
endtask

// Vertex and edge totals share the same 32-bit layout
task automatic check_count(input string name,
	input cu_arbiter_pkg::vertex_count_t actual,
	input cu_arbiter_pkg::vertex_count_t expected);
	if (actual !== expected)
		fail_run($sformatf("Fail at %0t: %s = %0d, expected %0d", $time, name, actual, expected));
endtask

`endif

// ==== tests/tb_cu_arbiter_control.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the CU read-command arbiter. Random CU traffic, bus
// grants, responses and done counts run against a queue model.
// Inputs change on the falling edge, outputs are checked there too
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_cu_arbiter_control;

	logic                                        clock;
	logic                                        rstn;
	logic [cu_arbiter_pkg::NUM_CU-1:0]           cu_req_valid;
	cu_arbiter_pkg::cu_read_req_t                cu_req [cu_arbiter_pkg::NUM_CU];
	logic [cu_arbiter_pkg::NUM_CU-1:0]           cu_req_ready;
	logic                                        mem_alfull;
	logic                                        bus_grant;
	logic                                        bus_request;
	logic                                        read_command_valid;
	cu_arbiter_pkg::read_command_t               read_command;
	logic                                        read_response_valid;
	cu_arbiter_pkg::read_response_t              read_response;
	logic [cu_arbiter_pkg::NUM_CU-1:0]           cu_resp_valid;
	logic [cu_arbiter_pkg::DATA_W-1:0]           cu_resp;
	cu_arbiter_pkg::vertex_count_t               vertex_done_partial [cu_arbiter_pkg::NUM_CU];
	cu_arbiter_pkg::edge_count_t                 edge_done_partial [cu_arbiter_pkg::NUM_CU];
	cu_arbiter_pkg::vertex_count_t               vertex_done_total;
	cu_arbiter_pkg::edge_count_t                 edge_done_total;

	// Model: accepted requests per CU, plus the order they were accepted in
	cu_arbiter_pkg::cu_read_req_t                pending [cu_arbiter_pkg::NUM_CU][$];
	logic [cu_arbiter_pkg::CU_ID_W-1:0]          accept_order [$];
	logic [cu_arbiter_pkg::CU_ID_W-1:0]          last_winner;
	logic [cu_arbiter_pkg::NUM_CU-1:0]           taken;
	int                                          accepted;

	// Inputs as seen at the last rising edge
	logic                                        prev_grant;
	logic                                        prev_alfull;
	logic                                        prev_resp_valid;
	cu_arbiter_pkg::read_response_t              prev_resp;
	cu_arbiter_pkg::vertex_count_t               prev_vertex_sum;
	cu_arbiter_pkg::edge_count_t                 prev_edge_sum;

	// Traffic shape
	bit                                          all_valid;
	bit                                          quiet_bus;
	bit                                          no_new;

	`include "tb_checks.svh"

	always #4 clock = ~clock;

	cu_arbiter_control cu_arbiter_control_inst (
		.clock              (clock),
		.rstn               (rstn),
		.cu_req_valid       (cu_req_valid),
		.cu_req             (cu_req),
		.cu_req_ready       (cu_req_ready),
		.mem_alfull         (mem_alfull),
		.bus_grant          (bus_grant),
		.bus_request        (bus_request),
		.read_command_valid (read_command_valid),
		.read_command       (read_command),
		.read_response_valid(read_response_valid),
		.read_response      (read_response),
		.cu_resp_valid      (cu_resp_valid),
		.cu_resp            (cu_resp),
		.vertex_done_partial(vertex_done_partial),
		.edge_done_partial  (edge_done_partial),
		.vertex_done_total  (vertex_done_total),
		.edge_done_total    (edge_done_total)
	);

	//////////////////////////////////////////////////////////////////////
	// Output checks, registered results of the last rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic check_outputs();
		cu_arbiter_pkg::read_command_t     exp_cmd;
		cu_arbiter_pkg::read_response_t    got_resp;
		logic [cu_arbiter_pkg::NUM_CU-1:0] exp_flags;
		logic [cu_arbiter_pkg::CU_ID_W-1:0] cu;
		if (prev_alfull)
			check_bit("bus_request", bus_request, 1'b0);
		// One issued command per grant, one cycle later
		check_bit("read_command_valid", read_command_valid, prev_grant);
		if (read_command_valid) begin
			if (accept_order.size() == 0) begin
				fail_run("A read command was issued with no accepted CU request outstanding");
			end else begin
				cu = accept_order.pop_front();
				exp_cmd.cu_id = cu;
				exp_cmd.addr  = pending[cu][0].addr;
				exp_cmd.size  = pending[cu][0].size;
				void'(pending[cu].pop_front());
				check_command("read_command", read_command, exp_cmd);
			end
		end
		exp_flags = '0;
		if (prev_resp_valid)
			exp_flags[prev_resp.cu_id] = 1'b1;
		check_flags("cu_resp_valid", cu_resp_valid, exp_flags);
		if (prev_resp_valid) begin
			got_resp.cu_id = '0;
			for (int k = 0; k < cu_arbiter_pkg::NUM_CU; k++)
				if (cu_resp_valid[k])
					got_resp.cu_id = cu_arbiter_pkg::CU_ID_W'(k);
			got_resp.data = cu_resp;
			check_response("cu_resp", got_resp, prev_resp);
		end
		check_count("vertex_done_total", vertex_done_total, prev_vertex_sum);
		check_count("edge_done_total", edge_done_total, prev_edge_sum);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and handshake model
	//////////////////////////////////////////////////////////////////////

	task automatic drive_inputs();
		cu_arbiter_pkg::vertex_count_t vsum;
		cu_arbiter_pkg::edge_count_t   esum;
		vsum = '0;
		esum = '0;
		for (int i = 0; i < cu_arbiter_pkg::NUM_CU; i++) begin
			// A request stays put until it is taken
			if (taken[i] || !cu_req_valid[i]) begin
				cu_req_valid[i] = !no_new && (all_valid || ($urandom % 3 == 0));
				cu_req[i].addr  = $urandom;
				cu_req[i].size  = cu_arbiter_pkg::SIZE_W'($urandom);
			end
			vertex_done_partial[i] = $urandom;
			edge_done_partial[i]   = $urandom;
			vsum = vsum + vertex_done_partial[i];
			esum = esum + edge_done_partial[i];
		end
		mem_alfull = !quiet_bus && ($urandom % 6 == 0);
		bus_grant  = bus_request && (quiet_bus || ($urandom % 3 != 0));
		read_response_valid = ($urandom % 2 == 0);
		read_response.cu_id = cu_arbiter_pkg::CU_ID_W'($urandom);
		read_response.data  = {$urandom, $urandom};
		prev_grant      = bus_grant;
		prev_alfull     = mem_alfull;
		prev_resp_valid = read_response_valid;
		prev_resp       = read_response;
		prev_vertex_sum = vsum;
		prev_edge_sum   = esum;
	endtask

	// Ready is settled here and holds until the next rising edge
	task automatic record_accepts();
		logic [cu_arbiter_pkg::CU_ID_W-1:0] idx;
		logic [cu_arbiter_pkg::CU_ID_W-1:0] want;
		logic [cu_arbiter_pkg::NUM_CU-1:0]  exp_ready;
		bit                                 found;
		taken = cu_req_valid & cu_req_ready;
		if (cu_req_ready != '0) begin
			// Round robin, first valid CU after the last winner
			found = 1'b0;
			want  = last_winner;
			for (int k = 1; k <= cu_arbiter_pkg::NUM_CU; k++) begin
				idx = cu_arbiter_pkg::CU_ID_W'((int'(last_winner) + k) % cu_arbiter_pkg::NUM_CU);
				if (!found && cu_req_valid[idx]) begin
					want  = idx;
					found = 1'b1;
				end
			end
			exp_ready = '0;
			exp_ready[want] = 1'b1;
			check_flags("cu_req_ready", cu_req_ready, exp_ready);
			last_winner = want;
			accept_order.push_back(want);
			pending[want].push_back(cu_req[want]);
			accepted++;
		end
	endtask

	task automatic step_cycle();
		@(negedge clock);
		check_outputs();
		drive_inputs();
		#1;
		record_accepts();
	endtask

	task automatic run_phase(input int target, input string what);
		int start;
		int cycles;
		start  = accepted;
		cycles = 0;
		while (accepted - start < target) begin
			if (cycles >= 4000) begin
				fail_run({"Timeout: CU requests stopped being accepted during ", what});
			end else begin
				step_cycle();
				cycles++;
			end
		end
	endtask

	// Stop new requests and grant freely until everything is issued
	task automatic drain_commands();
		int cycles;
		no_new    = 1'b1;
		quiet_bus = 1'b1;
		all_valid = 1'b0;
		cycles    = 0;
		while (accept_order.size() != 0 || cu_req_valid != '0) begin
			if (cycles >= 2000) begin
				fail_run("Timeout: accepted commands never left on the memory bus");
			end else begin
				step_cycle();
				cycles++;
			end
		end
		// Anything issued now would be a duplicate
		repeat (40) step_cycle();
	endtask

	initial begin
		void'($urandom(32'h8fd8));
		clock = 1'b0;
		rstn  = 1'b0;
		cu_req_valid = '0;
		for (int i = 0; i < cu_arbiter_pkg::NUM_CU; i++) begin
			cu_req[i]              = '0;
			vertex_done_partial[i] = '0;
			edge_done_partial[i]   = '0;
		end
		mem_alfull          = 1'b0;
		bus_grant           = 1'b0;
		read_response_valid = 1'b0;
		read_response       = '0;
		prev_grant = 1'b0;
		prev_alfull = 1'b0;
		prev_resp_valid = 1'b0;
		prev_resp = '0;
		prev_vertex_sum = '0;
		prev_edge_sum = '0;
		taken = '0;
		last_winner = cu_arbiter_pkg::CU_ID_W'(cu_arbiter_pkg::NUM_CU - 1);
		accepted = 0;
		all_valid = 1'b0;
		quiet_bus = 1'b0;
		no_new = 1'b0;

		// Reset state of all outputs
		repeat (16) begin
			@(negedge clock);
			check_bit("bus_request", bus_request, 1'b0);
			check_bit("read_command_valid", read_command_valid, 1'b0);
			check_flags("cu_req_ready", cu_req_ready, '0);
			check_flags("cu_resp_valid", cu_resp_valid, '0);
			check_count("vertex_done_total", vertex_done_total, '0);
			check_count("edge_done_total", edge_done_total, '0);
		end
		rstn = 1'b1;

		run_phase(300, "random traffic");
		// All CUs busy, no bus back-pressure
		all_valid = 1'b1;
		quiet_bus = 1'b1;
		run_phase(60, "full rotation");
		all_valid = 1'b0;
		quiet_bus = 1'b0;
		run_phase(200, "random traffic after rotation");
		drain_commands();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
